//--- src.f
src/div_pkg.sv
src/div_pipe_reg.sv
src/div_operand_prep.sv
src/div_iter_core.sv
src/div_result_fix.sv
src/div_unit_top.sv
tb/div_unit_checker.sv
tb/tb_div_unit.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_div_unit
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# the run passes only if the pass message shows up as a line of its own
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit import div_pkg::*; ();

    localparam int N_BASIC  = 32;   // 4 ops x 8 operand pairs
    localparam int N_DBZ    = 8;
    localparam int N_OVF    = 4;
    localparam int N_RAND   = 300;
    localparam int N_STREAM = 40;
    localparam int N_REQ    = N_BASIC + N_DBZ + N_OVF + N_RAND + N_STREAM;
    localparam int TIMEOUT_CYCLES = N_REQ * (XLEN + 8) + 1000;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic     clk;
    logic     rst;
    logic     i_req_valid;
    logic     o_req_ready;
    div_req_t i_req;
    logic     o_rsp_valid;
    logic     i_rsp_ready;
    div_rsp_t o_rsp;

    div_rsp_t exp_q[$];             // expected responses, request order
    int       req_cnt  = 0;
    int       rsp_cnt  = 0;
    int       err_cnt  = 0;
    int       chk_cnt  = 0;
    int       tag_cnt  = 0;
    int       test_cnt = 0;
    int       req_mark;
    int       rsp_mark;
    int       err_mark;
    logic     bp_on    = 1'b0;      // random stall on the response side
    string    test_name;

    div_unit_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // ISA rules for the M extension divides
    function automatic div_rsp_t ref_div(input alu_t op, input logic [TAG_W-1:0] tag,
                                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        div_rsp_t r;
        logic     is_signed;
        logic     is_rem;
        is_signed = (op == DIV) || (op == REM);
        is_rem    = (op == REM) || (op == REMU);
        r.tag = tag;
        r.dbz = 1'b0;
        r.ovf = 1'b0;
        if (b == '0) begin
            r.dbz    = 1'b1;
            r.result = is_rem ? a : '1;
        end else if (is_signed && (a == MOST_NEG) && (b == '1)) begin
            r.ovf    = 1'b1;
            r.result = is_rem ? '0 : MOST_NEG;
        end else if (is_signed) begin
            // SV truncates toward zero, remainder takes the dividend sign
            r.result = is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        end else begin
            r.result = is_rem ? a % b : a / b;
        end
        return r;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERROR: [%0t] %s mismatch, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // offer one request, return 1 ns after the edge that took it
    task automatic send_req(input alu_t op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        logic accepted;
        logic [TAG_W-1:0] tag;
        tag         = tag_cnt[TAG_W-1:0];
        i_req_valid = 1'b1;
        i_req.op    = op;
        i_req.tag   = tag;
        i_req.a     = a;
        i_req.b     = b;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = o_req_ready;     // stable mid cycle
            @(posedge clk);
            #1;
        end
        exp_q.push_back(ref_div(op, tag, a, b));
        tag_cnt++;
        req_cnt++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        req_mark  = req_cnt;
        rsp_mark  = rsp_cnt;
        err_mark  = err_cnt;
        test_cnt++;
    endtask

    // drop valid, wait for the pipe to drain, report
    task automatic finish_test();
        i_req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
        check_equal(64'(rsp_cnt - rsp_mark), 64'(req_cnt - req_mark), "response count");
        $display("%-8s %4d requests, %0d errors", test_name, req_cnt - req_mark,
                 err_cnt - err_mark);
    endtask

    // response side ready, 30% stall when enabled
    initial begin
        i_rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (bp_on) begin
                i_rsp_ready = ($urandom_range(99) >= 30);
            end else begin
                i_rsp_ready = 1'b1;
            end
        end
    end

    // scoreboard, handshake decided at mid cycle
    always @(negedge clk) begin
        div_rsp_t exp_rsp;
        if (!rst && o_rsp_valid && i_rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response with tag %0d at %0t, no request pending",
                         o_rsp.tag, $time);
                err_cnt++;
            end else begin
                exp_rsp = exp_q.pop_front();
                check_equal(64'(o_rsp), 64'(exp_rsp), "response");
            end
            rsp_cnt++;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, responses still missing", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        int               basic_a[8];
        int               basic_b[8];
        alu_t             op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        void'($urandom(32'hcc2c13af));
        rst         = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        basic_a = '{20, -20, 20, -20, 3, -3, 7, -7};   // all sign mixes, a < b, a == b
        basic_b = '{3, 3, -3, -3, 20, 20, 7, 7};
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        start_test("basic");
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 8; k++) begin
                send_req(alu_t'(2'(i)), basic_a[k], basic_b[k]);
            end
        end
        finish_test();

        start_test("dbz");
        for (int i = 0; i < 4; i++) begin
            send_req(alu_t'(2'(i)), XLEN'(1234567), '0);
            send_req(alu_t'(2'(i)), XLEN'(-77), '0);
        end
        finish_test();

        start_test("ovf");
        for (int i = 0; i < 4; i++) begin
            send_req(alu_t'(2'(i)), MOST_NEG, '1);   // unsigned ops give plain results
        end
        finish_test();

        start_test("random");
        bp_on = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            op = alu_t'(2'($urandom_range(3)));
            a  = ($urandom_range(15) == 0) ? MOST_NEG : XLEN'($urandom);
            b  = ($urandom_range(7) == 0) ? XLEN'($urandom_range(15)) : XLEN'($urandom);
            send_req(op, a, b);
        end
        finish_test();
        bp_on = 1'b0;

        start_test("stream");
        for (int i = 0; i < N_STREAM; i++) begin
            op = alu_t'(2'($urandom_range(3)));
            a  = XLEN'($urandom);
            b  = XLEN'($urandom_range(1000) + 1);
            if (i % 6 == 0) begin
                b = '0;                                  // dbz in the stream
            end else if (i % 6 == 3) begin
                op = (i % 4 == 1) ? DIV : REM;           // ovf in the stream
                a  = MOST_NEG;
                b  = '1;
            end
            send_req(op, a, b);
        end
        finish_test();

        $display("summary: %0d tests, %0d requests, %0d checks, %0d errors",
                 test_cnt, req_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/div_unit_checker.sv
`timescale 1ns/1ps

// protocol checks on the response port of the divide unit
module div_unit_checker import div_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     i_rsp_valid,
    input logic     i_rsp_ready,
    input div_rsp_t i_rsp
);

    // a stalled response keeps its valid and its payload
    property p_rsp_hold;
        @(posedge clk) disable iff (rst)
        (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp));
    endproperty

    // nothing comes out of a unit under reset
    property p_rsp_idle_in_reset;
        @(posedge clk) rst |=> !i_rsp_valid;
    endproperty

    // dbz and ovf never together
    // an ovf response carries INT_MIN (div) or zero (rem)
    property p_flags_exclusive;
        @(posedge clk) disable iff (rst)
        i_rsp_valid |-> !(i_rsp.dbz && i_rsp.ovf)
            && (!i_rsp.ovf || (i_rsp.result == INT_MIN) || (i_rsp.result == '0));
    endproperty

    a_rsp_hold: assert property (p_rsp_hold)
        else $error("response changed or dropped while stalled");
    a_rsp_idle_in_reset: assert property (p_rsp_idle_in_reset)
        else $error("response valid during reset");
    a_flags_exclusive: assert property (p_flags_exclusive)
        else $error("dbz and ovf both set, or overflow result out of range");

endmodule

bind div_unit_top div_unit_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .i_rsp       (o_rsp)
);

//--- src/div_unit_top.sv
`timescale 1ns/1ps

// in slice -> prep -> core -> fix -> out slice
module div_unit_top import div_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // request
    input  logic     i_req_valid,
    output logic     o_req_ready,
    input  div_req_t i_req,
    // response
    output logic     o_rsp_valid,
    input  logic     i_rsp_ready,
    output div_rsp_t o_rsp
);

    // in slice -> prep
    logic      req_valid;
    logic      req_ready;
    div_req_t  req_q;

    // prep -> core
    logic      work_valid;
    logic      work_ready;
    div_work_t work;

    // core -> fix
    logic      core_valid;
    logic      core_ready;
    div_core_t core_res;

    // fix -> out slice
    logic      rsp_valid;
    logic      rsp_ready;
    div_rsp_t  rsp;

    div_pipe_reg #(
        .T (div_req_t)
    ) i_req_slice (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .i_data  (i_req),
        .o_valid (req_valid),
        .i_ready (req_ready),
        .o_data  (req_q)
    );

    div_operand_prep i_prep (
        .clk     (clk),
        .rst     (rst),
        .i_valid (req_valid),
        .o_ready (req_ready),
        .i_req   (req_q),
        .o_valid (work_valid),
        .i_ready (work_ready),
        .o_work  (work)
    );

    div_iter_core #(
        .WIDTH (XLEN)
    ) i_core (
        .clk     (clk),
        .rst     (rst),
        .i_valid (work_valid),
        .o_ready (work_ready),
        .i_work  (work),
        .o_valid (core_valid),
        .i_ready (core_ready),
        .o_res   (core_res)
    );

    div_result_fix i_fix (
        .clk     (clk),
        .rst     (rst),
        .i_valid (core_valid),
        .o_ready (core_ready),
        .i_res   (core_res),
        .o_valid (rsp_valid),
        .i_ready (rsp_ready),
        .o_rsp   (rsp)
    );

    div_pipe_reg #(
        .T (div_rsp_t)
    ) i_rsp_slice (
        .clk     (clk),
        .rst     (rst),
        .i_valid (rsp_valid),
        .o_ready (rsp_ready),
        .i_data  (rsp),
        .o_valid (o_rsp_valid),
        .i_ready (i_rsp_ready),
        .o_data  (o_rsp)
    );

endmodule

//--- src/div_result_fix.sv
`timescale 1ns/1ps

// sign fixup and ISA results for the special cases
module div_result_fix import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // core side
    input  logic      i_valid,
    output logic      o_ready,
    input  div_core_t i_res,
    // output side
    output logic      o_valid,
    input  logic      i_ready,
    output div_rsp_t  o_rsp
);

    logic     valid_q;
    div_rsp_t rsp_q;
    div_rsp_t rsp_d;

    logic [XLEN-1:0] q_fix;
    logic [XLEN-1:0] r_fix;
    logic [XLEN-1:0] special_res;

    always_comb begin
        q_fix = i_res.work.neg_q ? -i_res.q : i_res.q;
        r_fix = i_res.work.neg_r ? -i_res.r : i_res.r;

        // dbz: q all ones, r = dividend
        // ovf: q = INT_MIN, r = 0
        if (i_res.work.dbz) begin
            special_res = i_res.work.is_rem ? i_res.work.a_raw : '1;
        end else begin
            special_res = i_res.work.is_rem ? '0 : INT_MIN;
        end

        rsp_d.tag = i_res.work.tag;
        if (i_res.work.special) begin
            rsp_d.result = special_res;
        end else begin
            rsp_d.result = i_res.work.is_rem ? r_fix : q_fix;
        end
        rsp_d.dbz = i_res.work.dbz;
        rsp_d.ovf = i_res.work.ovf;
    end

    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            rsp_q <= rsp_d;
        end
    end

    assign o_valid = valid_q;
    assign o_rsp   = rsp_q;

endmodule

//--- src/div_iter_core.sv
`timescale 1ns/1ps

// restoring shift-subtract divider, one quotient bit per cycle
module div_iter_core import div_pkg::*; #(
    parameter int WIDTH = 32    // operand width, 8 or more
) (
    input  logic      clk,
    input  logic      rst,
    // prep side
    input  logic      i_valid,
    output logic      o_ready,
    input  div_work_t i_work,
    // fix side
    output logic      o_valid,
    input  logic      i_ready,
    output div_core_t o_res
);

    localparam int             CNT_W = $clog2(WIDTH);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(WIDTH - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;       // iteration index
    div_work_t        work_q;    // item under way
    logic [WIDTH:0]   rem_q;     // partial remainder, one bit wider
    logic [WIDTH-1:0] quo_q;     // dividend shifts out, quotient shifts in

    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   divisor;
    logic             fits;

    logic load;

    assign load = (state == ST_IDLE) && i_valid;

    always_comb begin
        shifted = {rem_q[WIDTH-1:0], quo_q[WIDTH-1]};  // bring down next dividend bit
        divisor = {1'b0, work_q.b_mag};
        fits    = (shifted >= divisor);
    end

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_valid) begin
                        state <= ST_CALC;
                        // special items leave after one pass, no iterations
                        cnt   <= i_work.special ? LAST : '0;
                    end
                end
                ST_CALC: begin
                    if (cnt == LAST) begin
                        state <= ST_DONE;
                    end
                    cnt <= cnt + 1'b1;
                end
                ST_DONE: begin
                    if (i_ready) begin
                        state <= ST_IDLE;   // result taken
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (load) begin
            work_q <= i_work;
            rem_q  <= '0;
            quo_q  <= i_work.special ? '0 : i_work.a_mag;  // specials carry zeros
        end else if ((state == ST_CALC) && !work_q.special) begin
            rem_q <= fits ? (shifted - divisor) : shifted;   // restore when it doesn't fit
            quo_q <= {quo_q[WIDTH-2:0], fits};
        end
    end

    assign o_ready = (state == ST_IDLE);
    assign o_valid = (state == ST_DONE);

    always_comb begin
        o_res.work = work_q;
        o_res.q    = quo_q;
        o_res.r    = rem_q[WIDTH-1:0];   // top bit is always clear at the end
    end

endmodule

//--- src/div_operand_prep.sv
`timescale 1ns/1ps

// decode + special case detect, one registered stage
module div_operand_prep import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // request side
    input  logic      i_valid,
    output logic      o_ready,
    input  div_req_t  i_req,
    // core side
    output logic      o_valid,
    input  logic      i_ready,
    output div_work_t o_work
);

    logic      valid_q;
    div_work_t work_q;
    div_work_t work_d;

    logic is_signed;
    logic a_neg;
    logic b_neg;
    logic dbz;
    logic ovf;

    always_comb begin
        is_signed = (i_req.op == DIV) || (i_req.op == REM);
        a_neg     = is_signed && i_req.a[XLEN-1];    // sign only counts for signed ops
        b_neg     = is_signed && i_req.b[XLEN-1];

        dbz = (i_req.b == '0);
        // INT_MIN / -1, unsigned ops never overflow
        ovf = is_signed && (i_req.a == INT_MIN) && (i_req.b == '1);

        work_d.a_mag   = a_neg ? -i_req.a : i_req.a;
        work_d.b_mag   = b_neg ? -i_req.b : i_req.b;
        work_d.neg_q   = a_neg ^ b_neg;             // signs differ
        work_d.neg_r   = a_neg;                     // remainder follows dividend
        work_d.is_rem  = (i_req.op == REM) || (i_req.op == REMU);
        work_d.special = dbz || ovf;
        work_d.dbz     = dbz;
        work_d.ovf     = ovf;
        work_d.a_raw   = i_req.a;
        work_d.tag     = i_req.tag;
    end

    // same handshake as a register slice
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            work_q <= work_d;
        end
    end

    assign o_valid = valid_q;
    assign o_work  = work_q;

endmodule

//--- src/div_pipe_reg.sv
`timescale 1ns/1ps

// single entry slice, full throughput when downstream drains every cycle
module div_pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    // upstream side
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    // downstream side
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic valid_q;
    T     data_q;

    // free slot, or the held item leaves this cycle
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;     // refill or go empty
        end
    end

    // payload only, no reset needed
    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

//--- src/div_pkg.sv
package div_pkg;

    // datapath widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 5;              // rd index travels with the op

    // most negative signed value, quotient of the overflow case
    localparam logic [XLEN-1:0] INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

    // divide ops of the M extension
    typedef enum logic [1:0] {
        DIV  = 2'b00,   // signed quotient
        DIVU = 2'b01,   // unsigned quotient
        REM  = 2'b10,   // signed remainder
        REMU = 2'b11    // unsigned remainder
    } alu_t;

    // request from issue
    typedef struct packed {
        alu_t             op;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  a;      // dividend
        logic [XLEN-1:0]  b;      // divisor
    } div_req_t;

    // prep -> core
    typedef struct packed {
        logic [XLEN-1:0]  a_mag;  // |a| for signed ops
        logic [XLEN-1:0]  b_mag;  // |b| for signed ops
        logic             neg_q;  // signs differ
        logic             neg_r;  // dividend negative
        logic             is_rem;
        logic             special; // dbz or ovf, core skips iterations
        logic             dbz;
        logic             ovf;
        logic [XLEN-1:0]  a_raw;  // remainder of a divide by zero
        logic [TAG_W-1:0] tag;
    } div_work_t;

    // core -> fix, unsigned results beside the work item
    typedef struct packed {
        div_work_t        work;
        logic [XLEN-1:0]  q;
        logic [XLEN-1:0]  r;
    } div_core_t;

    // response to writeback
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  result;
        logic             dbz;
        logic             ovf;
    } div_rsp_t;

endpackage
